// File: filelist.f
logic/bp_pkg.sv
logic/bundle_decode.sv
logic/pattern_table.sv
logic/branch_resolve.sv
logic/steer_select.sv
logic/branch_predict_unit.sv
bench/branch_predict_unit_props.sv
bench/branch_predict_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module branch_predict_unit_tb \
  -f filelist.f || exit 1

out="$(./obj_dir/Vbranch_predict_unit_tb 2>&1)"
echo "$out"

echo "$out" | grep -qx "Test passed" && exit 0 || exit 1

// File: bench/branch_predict_unit_tb.sv
/*
  directed testbench for the branch prediction unit, keeps its own
  model of all sixteen counters and checks steer, prediction and flush
*/
`timescale 1ns/1ps
`default_nettype none

module branch_predict_unit_tb;

  logic                  clock;
  logic                  rst_n;
  logic                  fetch_valid;
  bp_pkg::fetch_bundle_t fetch;
  logic                  stall;
  logic                  resolve_valid;
  bp_pkg::resolve_t      resolve;
  bp_pkg::steer_t        steer;
  logic [3:0]            prediction;
  logic                  mispredict;

  logic [1:0] model [bp_pkg::lane_count][bp_pkg::set_count];  // [slot][set]
  int         seed = 28;
  int         wait_limit = 20;  // cycles before a wait gives up

  branch_predict_unit dut_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .fetch_valid   (fetch_valid),
    .fetch         (fetch),
    .stall         (stall),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .steer         (steer),
    .prediction    (prediction),
    .mispredict    (mispredict)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else
      stop_on_error($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want));
  endtask

  // saturating two-bit counter step
  function automatic logic [1:0] saturate_step(input logic [1:0] c, input logic taken);
    if (taken)
      return (c == 2'd3) ? c : c + 2'd1;
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  // resolved outcome by opcode
  function automatic logic branch_outcome(input logic [1:0] op, input logic [7:0] a,
                                          input logic [7:0] b);
    case (op)
      bp_pkg::op_beq: return a == b;
      bp_pkg::op_bne: return a != b;
      bp_pkg::op_jmp: return 1'b1;
      default:        return 1'b0;
    endcase
  endfunction

  function automatic logic [3:0] expected_prediction(input logic [1:0] set);
    logic [3:0] p;
    for (int i = 0; i < bp_pkg::lane_count; i++)
      p[i] = model[i][set][1];  // upper bit
    return p;
  endfunction

  // {taken, slot} of the oldest redirecting slot
  function automatic logic [2:0] expected_steer(input logic [1:0] set, input logic [7:0] ops);
    logic [2:0] r;
    logic [1:0] op;
    logic       hit;
    r = 3'b000;
    for (int i = 0; i < bp_pkg::lane_count; i++) begin
      op  = ops[2*i +: 2];
      hit = (op == bp_pkg::op_jmp) ||
            ((op == bp_pkg::op_beq || op == bp_pkg::op_bne) && model[i][set][1]);
      if (hit && !r[2])
        r = {1'b1, 2'(i)};
    end
    return r;
  endfunction

  task automatic apply_reset();
    rst_n = 1'b0;
    for (int b = 0; b < bp_pkg::lane_count; b++)
      for (int s = 0; s < bp_pkg::set_count; s++)
        model[b][s] = 2'd1;  // weak not taken
    repeat (3) begin
      @(negedge clock);
      check_value("mispredict", 32'(mispredict), 32'd0);
      check_value("steer.valid", 32'(steer.valid), 32'd0);
      check_value("prediction", 32'(prediction), 32'd0);
    end
    rst_n = 1'b1;
  endtask

  task automatic wait_for_steer();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!steer.valid && cycles < wait_limit) begin
      @(negedge clock);
      cycles++;
    end
    assert (steer.valid) else stop_on_error("steer.valid never rose after a fetch bundle");
    // one cycle from the accepting edge
    assert (cycles == 0) else
      stop_on_error("steer.valid came later than one cycle after the bundle");
  endtask

  // one bundle in, compare steer and prediction with the model
  task automatic lookup_and_check(input logic [1:0] set, input logic [7:0] ops);
    logic [2:0] want;
    fetch_valid = 1'b1;
    fetch       = bp_pkg::fetch_bundle_t'({set, ops});
    wait_for_steer();
    want = expected_steer(set, ops);
    check_value("prediction", 32'(prediction), 32'(expected_prediction(set)));
    check_value("steer.taken", 32'(steer.taken), 32'(want[2]));
    check_value("steer.slot", 32'(steer.slot), 32'(want[1:0]));
    check_value("steer.flush", 32'(steer.flush), 32'd0);
    fetch_valid = 1'b0;
  endtask

  // one resolve strobe, flush expected in the following cycle
  task automatic send_resolve(input logic [1:0] set, input logic [1:0] slot,
                              input bp_pkg::opcode_e op, input logic [7:0] a,
                              input logic [7:0] b, input logic predicted);
    logic taken;
    logic cond;
    logic wrong;
    taken = branch_outcome(op, a, b);
    cond  = (op == bp_pkg::op_beq) || (op == bp_pkg::op_bne);
    wrong = cond && (taken != predicted);
    resolve_valid = 1'b1;
    resolve       = bp_pkg::resolve_t'({set, slot, op, a, b, predicted});
    if (cond)
      model[slot][set] = saturate_step(model[slot][set], taken);
    @(negedge clock);
    check_value("mispredict", 32'(mispredict), 32'(wrong));
    check_value("steer.flush", 32'(steer.flush), 32'(wrong));
    resolve_valid = 1'b0;
  endtask

  task automatic reset_state_check();
    for (int s = 0; s < bp_pkg::set_count; s++) begin
      lookup_and_check(2'(s), {4{bp_pkg::op_beq}});
      check_value("prediction", 32'(prediction), 32'd0);
    end
  endtask

  // set 1 slot 2 up to strong taken and back down
  task automatic train_one_counter();
    for (int k = 0; k < 3; k++) begin
      send_resolve(2'd1, 2'd2, bp_pkg::op_beq, 8'h5a, 8'h5a, model[2][1][1]);
      lookup_and_check(2'd1, {4{bp_pkg::op_beq}});
      check_value("prediction", 32'(prediction), 32'h4);  // slot 2 only
    end
    lookup_and_check(2'd0, {4{bp_pkg::op_beq}});
    for (int k = 0; k < 3; k++) begin
      send_resolve(2'd1, 2'd2, bp_pkg::op_bne, 8'h33, 8'h33, model[2][1][1]);
      lookup_and_check(2'd1, {4{bp_pkg::op_beq}});
    end
    check_value("prediction", 32'(prediction), 32'd0);
  endtask

  task automatic random_resolve_sweep();
    int              rnd;
    bp_pkg::opcode_e op;
    logic [7:0]      a;
    logic [7:0]      b;
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      op  = rnd[0] ? bp_pkg::op_beq : bp_pkg::op_bne;
      a   = 8'($random(seed));
      b   = rnd[1] ? a : 8'($random(seed));  // equal about half the time
      send_resolve(rnd[3:2], rnd[5:4], op, a, b, rnd[6]);
    end
    // jumps never train and never flush, predicted bit alternates
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      send_resolve(rnd[3:2], rnd[5:4], bp_pkg::op_jmp, 8'(rnd), 8'h00, 1'(i));
    end
    for (int s = 0; s < bp_pkg::set_count; s++)
      lookup_and_check(2'(s), {4{bp_pkg::op_beq}});
  endtask

  task automatic steer_priority();
    repeat (2)
      send_resolve(2'd3, 2'd1, bp_pkg::op_beq, 8'h10, 8'h10, model[1][3][1]);
    // slot 3..0 is alu, jmp, beq, alu
    lookup_and_check(2'd3, {bp_pkg::op_alu, bp_pkg::op_jmp, bp_pkg::op_beq, bp_pkg::op_alu});
    check_value("steer.slot", 32'(steer.slot), 32'd1);
    lookup_and_check(2'd3, {4{bp_pkg::op_alu}});
    check_value("steer.taken", 32'(steer.taken), 32'd0);
  endtask

  task automatic stall_hold();
    logic [3:0] held;
    logic       dir;
    lookup_and_check(2'd2, {4{bp_pkg::op_beq}});
    held        = expected_prediction(2'd2);  // pre-stall bits of set 2
    dir         = !model[0][2][1];  // train against the current bit
    stall       = 1'b1;
    fetch_valid = 1'b1;
    repeat (3) begin
      send_resolve(2'd2, 2'd0, bp_pkg::op_beq, 8'h11, dir ? 8'h11 : 8'h22, held[0]);
      check_value("prediction", 32'(prediction), 32'(held));
      check_value("steer.valid", 32'(steer.valid), 32'd0);
    end
    stall = 1'b0;
    lookup_and_check(2'd2, {4{bp_pkg::op_beq}});
    check_value("prediction[0]", 32'(prediction[0]), 32'(!held[0]));
  endtask

  initial begin
    rst_n         = 1'b0;
    fetch_valid   = 1'b0;
    fetch         = '0;
    stall         = 1'b0;
    resolve_valid = 1'b0;
    resolve       = '0;
    apply_reset();
    reset_state_check();
    train_one_counter();
    random_resolve_sweep();
    steer_priority();
    stall_hold();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/branch_predict_unit_props.sv
/*
  bound checks on the pattern table, counter saturation at the top
  and prediction holding while fetch is stalled
*/
`timescale 1ns/1ps
`default_nettype none

module branch_predict_unit_props (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            stall,
  input  logic [bp_pkg::lane_count-1:0]   prediction,
  input  bp_pkg::counter_e                bank [bp_pkg::lane_count][bp_pkg::set_count]
);

  // every counter in every bank
  for (genvar b = 0; b < bp_pkg::lane_count; b++) begin : g_bank
    for (genvar s = 0; s < bp_pkg::set_count; s++) begin : g_set
      // one step down from the top is still the taken half
      strong_stays_taken: assert property (
        @(posedge clock) disable iff (!rst_n)
        bank[b][s] == bp_pkg::strong_taken |=> bank[b][s][1]
      ) else $error("bank %0d set %0d left the taken half from strong taken", b, s);
    end
  end

  // held prediction flop
  hold_under_stall: assert property (
    @(posedge clock) disable iff (!rst_n)
    stall |=> $stable(prediction)
  ) else $error("prediction changed across a stalled edge");

endmodule

// attach to every table instance
bind pattern_table branch_predict_unit_props props_i (
  .clock      (clock),
  .rst_n      (rst_n),
  .stall      (stall),
  .prediction (prediction),
  .bank       (bank)
);

`default_nettype wire

// File: logic/branch_predict_unit.sv
/*
  fetch side branch prediction unit, four slot bundles steered by a
  banked two-bit counter table trained from resolved branches
*/
`timescale 1ns/1ps
`default_nettype none

module branch_predict_unit (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            fetch_valid,
  input  bp_pkg::fetch_bundle_t           fetch,
  input  logic                            stall,
  input  logic                            resolve_valid,
  input  bp_pkg::resolve_t                resolve,
  output bp_pkg::steer_t                  steer,
  output logic [bp_pkg::lane_count-1:0]   prediction,
  output logic                            mispredict
);

  logic [bp_pkg::set_bits-1:0] lookup_set;  // raw set index into the table
  bp_pkg::decoded_t            decoded;     // registered slot masks
  bp_pkg::counter_update_t     update;      // training from execute

  // decode stage
  bundle_decode decode_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .stall       (stall),
    .lookup_set  (lookup_set),
    .decoded     (decoded)
  );

  // counter table, prediction also goes straight out
  pattern_table table_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .stall      (stall),
    .lookup_set (lookup_set),
    .update     (update),
    .prediction (prediction)
  );

  // execute stage, keeps training while fetch stalls
  branch_resolve resolve_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .update        (update),
    .mispredict    (mispredict)
  );

  steer_select select_i (
    .stall      (stall),
    .decoded    (decoded),
    .prediction (prediction),
    .mispredict (mispredict),
    .steer      (steer)
  );

endmodule

`default_nettype wire

// File: logic/steer_select.sv
/*
  result stage, picks the oldest slot that redirects fetch
  and passes a pending misprediction flush along with it
*/
`timescale 1ns/1ps
`default_nettype none

module steer_select (
  input  logic                            stall,
  input  bp_pkg::decoded_t                decoded,
  input  logic [bp_pkg::lane_count-1:0]   prediction,
  input  logic                            mispredict,
  output bp_pkg::steer_t                  steer
);

  logic [bp_pkg::lane_count-1:0] redirect;  // slots that change fetch flow
  logic [bp_pkg::lane_bits-1:0]  first;     // lowest redirecting slot
  logic                          any;

  // jumps always redirect, branches only when predicted taken
  assign redirect = decoded.jump_mask | (decoded.branch_mask & prediction);

  // lowest index wins, scan from the top so the last hit is the oldest
  always_comb begin
    first = '0;
    any   = 1'b0;
    for (int i = bp_pkg::lane_count - 1; i >= 0; i--) begin
      if (redirect[i]) begin
        first = bp_pkg::lane_bits'(i);
        any   = 1'b1;
      end
    end
  end

  always_comb begin
    steer.valid = decoded.valid && !stall;  // held bundle not reported twice
    steer.taken = any;
    steer.slot  = first;                    // zero when nothing redirects
    steer.flush = mispredict;               // flush outranks the prediction
  end

endmodule

`default_nettype wire

// File: logic/branch_resolve.sv
/*
  execute side of the predictor, evaluates resolved branches,
  issues counter updates and registers mispredictions
*/
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      resolve_valid,
  input  bp_pkg::resolve_t          resolve,
  output bp_pkg::counter_update_t   update,
  output logic                      mispredict
);

  logic taken;        // actual outcome of the resolving op
  logic conditional;  // beq or bne, the only ops the table tracks
  logic wrong;        // outcome disagrees with the steering bit

  // outcome from opcode and operand compare
  always_comb begin
    case (resolve.op)
      bp_pkg::op_beq: taken = (resolve.operand_a == resolve.operand_b);
      bp_pkg::op_bne: taken = (resolve.operand_a != resolve.operand_b);
      bp_pkg::op_jmp: taken = 1'b1;
      default:        taken = 1'b0;  // alu never redirects
    endcase
  end

  assign conditional = (resolve.op == bp_pkg::op_beq) ||
                       (resolve.op == bp_pkg::op_bne);

  // jumps are not predicted by the table so they cannot be wrong
  assign wrong = resolve_valid && conditional && (taken != resolve.predicted);

  // update goes to the table in the same cycle
  always_comb begin
    update.enable = resolve_valid && conditional;
    update.set    = resolve.set;
    update.slot   = resolve.slot;
    update.taken  = taken;
  end

  // one cycle pulse, lands while steer carries the flush
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n)
      mispredict <= 1'b0;
    else
      mispredict <= wrong;
  end

endmodule

`default_nettype wire

// File: logic/pattern_table.sv
/*
  banked pattern table, one bank of two-bit counters per slot position
  with a registered prediction vector and one update per cycle
*/
`timescale 1ns/1ps
`default_nettype none

module pattern_table (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            stall,
  input  logic [bp_pkg::set_bits-1:0]     lookup_set,
  input  bp_pkg::counter_update_t         update,
  output logic [bp_pkg::lane_count-1:0]   prediction
);

  // bank[slot][set]
  bp_pkg::counter_e bank [bp_pkg::lane_count][bp_pkg::set_count];

  // saturating step, taken counts up and not taken counts down
  function automatic bp_pkg::counter_e next_count(
    input bp_pkg::counter_e cur,
    input logic             taken
  );
    bp_pkg::counter_e nxt;
    nxt = cur;
    if (taken) begin
      if (cur != bp_pkg::strong_taken)
        nxt = bp_pkg::counter_e'(cur + 2'd1);
    end else begin
      if (cur != bp_pkg::strong_not_taken)
        nxt = bp_pkg::counter_e'(cur - 2'd1);
    end
    return nxt;
  endfunction

  // prediction flop, reads every bank at the same set
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      prediction <= '0;
    end else if (!stall) begin
      for (int b = 0; b < bp_pkg::lane_count; b++)
        prediction[b] <= bank[b][lookup_set][1];  // upper bit means taken
    end
  end

  // counter storage
  // a lookup on the same edge as an update still sees the old count
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < bp_pkg::lane_count; b++) begin
        for (int s = 0; s < bp_pkg::set_count; s++)
          bank[b][s] <= bp_pkg::weak_not_taken;  // start weakly not taken
      end
    end else if (update.enable) begin
      // single write port, slot picks the bank and set picks the entry
      bank[update.slot][update.set] <=
        next_count(bank[update.slot][update.set], update.taken);
    end
  end

endmodule

`default_nettype wire

// File: logic/bundle_decode.sv
/*
  bundle decode, classifies four fetch slots into branch and jump masks
  and registers them in step with the pattern table read
*/
`timescale 1ns/1ps
`default_nettype none

module bundle_decode (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic                          fetch_valid,
  input  bp_pkg::fetch_bundle_t         fetch,
  input  logic                          stall,
  output logic [bp_pkg::set_bits-1:0]   lookup_set,
  output bp_pkg::decoded_t              decoded
);

  logic [bp_pkg::lane_count-1:0] branch_mask;  // conditional slots this cycle
  logic [bp_pkg::lane_count-1:0] jump_mask;    // unconditional slots this cycle

  // table index goes out unregistered, table does the flop
  assign lookup_set = fetch.set;

  // per slot opcode classification
  always_comb begin
    branch_mask = '0;
    jump_mask   = '0;
    for (int i = 0; i < bp_pkg::lane_count; i++) begin
      case (fetch.op[i])
        bp_pkg::op_beq,
        bp_pkg::op_bne: branch_mask[i] = 1'b1;  // needs a counter
        bp_pkg::op_jmp: jump_mask[i]   = 1'b1;  // always redirects
        default: ;                              // alu, nothing to steer
      endcase
    end
  end

  // decode register, aligned with the prediction flop
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      decoded <= '0;  // valid low out of reset
    end else if (!stall) begin
      decoded.valid       <= fetch_valid;
      decoded.set         <= fetch.set;
      decoded.branch_mask <= branch_mask;
      decoded.jump_mask   <= jump_mask;
    end
    // stall high holds the whole bundle
  end

endmodule

`default_nettype wire

// File: logic/bp_pkg.sv
/*
  branch prediction unit shared sizes, encodings and bundle types
*/
`default_nettype none

package bp_pkg;

  localparam int lane_count   = 4;  // slots per fetch bundle, one bank each
  localparam int set_count    = 4;  // counter sets per bank
  localparam int set_bits     = 2;
  localparam int lane_bits    = 2;
  localparam int operand_bits = 8;  // resolve compare width

  // two-bit saturating counter, upper bit is the taken prediction
  typedef enum logic [1:0] {
    strong_not_taken = 2'd0,
    weak_not_taken   = 2'd1,
    weak_taken       = 2'd2,
    strong_taken     = 2'd3
  } counter_e;

  typedef enum logic [1:0] {
    op_alu = 2'd0,  // not a branch
    op_beq = 2'd1,  // taken on equal operands
    op_bne = 2'd2,  // taken on differing operands
    op_jmp = 2'd3   // unconditional, table never consulted
  } opcode_e;

  typedef struct packed {
    logic [set_bits-1:0]           set;
    opcode_e [lane_count-1:0]      op;  // op[0] is the oldest slot
  } fetch_bundle_t;

  typedef struct packed {
    logic                          valid;
    logic [set_bits-1:0]           set;
    logic [lane_count-1:0]         branch_mask;  // beq / bne slots
    logic [lane_count-1:0]         jump_mask;
  } decoded_t;

  typedef struct packed {
    logic [set_bits-1:0]           set;
    logic [lane_bits-1:0]          slot;
    opcode_e                       op;
    logic [operand_bits-1:0]       operand_a;
    logic [operand_bits-1:0]       operand_b;
    logic                          predicted;  // bit the branch was steered with
  } resolve_t;

  typedef struct packed {
    logic                          enable;
    logic [set_bits-1:0]           set;
    logic [lane_bits-1:0]          slot;
    logic                          taken;
  } counter_update_t;

  typedef struct packed {
    logic                          valid;
    logic                          taken;
    logic [lane_bits-1:0]          slot;
    logic                          flush;
  } steer_t;

endpackage

`default_nettype wire
